//--- hdl/cop_pkg.sv
/*
 * Shared definitions for the board glue between the main CPU, the 8751
 * protection MCU and the status port: data widths, port 2 control bit
 * positions and clock enable divide ratios
 */

package cop_pkg;

    localparam int BYTE_W = 8;
    localparam int WORD_W = 16;
    localparam int SEL_W  = 6;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [SEL_W-1:0]  sel_t;

    // MCU port 2 bits, active low except for the second select
    localparam int P2_SEL2_BIT    = 2;
    localparam int P2_IRQ_CLR_BIT = 3;
    localparam int P2_RDHI_BIT    = 4;
    localparam int P2_RDLO_BIT    = 5;
    localparam int P2_WRLO_BIT    = 6;
    localparam int P2_WRHI_BIT    = 7;

    // Divide ratios from the 24 MHz clock
    localparam int CEN_MCU_DIV = 3;   // 8 MHz
    localparam int CEN_OPL_DIV = 8;   // 3 MHz
    localparam int CEN_OPN_DIV = 16;  // 1.5 MHz

    // Status dump selector sits in the top two address bits
    localparam int ST_SEL_MSB = 7;

endpackage

//--- hdl/cop_cen_gen.sv
/*
 * Clock enable generator for the MCU and the two sound chips.
 * One-cycle pulses at 8, 3 and 1.5 MHz out of the 24 MHz clock
 */

`timescale 1ns/1ps

module cop_cen_gen import cop_pkg::*; (
    input  logic clk,
    input  logic rst24,
    output logic cen_mcu,
    output logic cen_opl,
    output logic cen_opn
);

    logic [$clog2(CEN_MCU_DIV)-1:0] mcu_cnt;
    // Shared counter keeps the two sound enables in phase
    logic [$clog2(CEN_OPN_DIV)-1:0] snd_cnt;

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            mcu_cnt <= '0;
            snd_cnt <= '0;
            cen_mcu <= 1'b0;
            cen_opl <= 1'b0;
            cen_opn <= 1'b0;
        end else begin
            if (mcu_cnt == CEN_MCU_DIV - 1) begin
                mcu_cnt <= '0;
            end else begin
                mcu_cnt <= mcu_cnt + 1'b1;
            end
            cen_mcu <= mcu_cnt == CEN_MCU_DIV - 1;

            snd_cnt <= snd_cnt + 1'b1;
            // Low bits wrap every 8 counts, the full counter every 16
            cen_opl <= &snd_cnt[$clog2(CEN_OPL_DIV)-1:0];
            cen_opn <= &snd_cnt;
        end
    end

    // The slow sound enable must never fall between fast ones
    a_opn_on_opl: assert property (
        @(posedge clk) disable iff (rst24) cen_opn |-> cen_opl
    ) else $error("cen_opn pulse without cen_opl");

endmodule

//--- hdl/cop_mcu_port_in.sv
/*
 * MCU input side. Latches either half of the CPU word for port 0,
 * raises the MCU interrupt on a rising CPU select and builds port 3
 */

`timescale 1ns/1ps

module cop_mcu_port_in import cop_pkg::*; (
    input  logic  clk,
    input  logic  rst24,
    input  word_t mcu_din,
    input  sel_t  mcu_sel,
    input  byte_t mcu_p2o,
    input  byte_t mcu_p3o,
    output byte_t mcu_p0i,
    output logic  mcu_intn,
    output byte_t mcu_p3i
);

    logic sel0_l;
    logic sel0_rise;
    logic irq_clr;

    assign sel0_rise = mcu_sel[0] & ~sel0_l;
    assign irq_clr   = ~mcu_p2o[P2_IRQ_CLR_BIT];

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            sel0_l   <= 1'b0;
            mcu_intn <= 1'b1;
            mcu_p0i  <= '0;
        end else begin
            sel0_l <= mcu_sel[0];

            // MCU acknowledge wins over a fresh request
            if (irq_clr) begin
                mcu_intn <= 1'b1;
            end else if (sel0_rise) begin
                mcu_intn <= 1'b0;
            end

            // Low byte has priority when both reads are active
            if (!mcu_p2o[P2_RDLO_BIT]) begin
                mcu_p0i <= mcu_din[7:0];
            end else if (!mcu_p2o[P2_RDHI_BIT]) begin
                mcu_p0i <= mcu_din[15:8];
            end
        end
    end

    // Upper selects on top, MCU's own port 3 looped back below
    assign mcu_p3i = {mcu_sel[5:3], mcu_p3o[4:0]};

    // A pending interrupt only goes away through the MCU clear bit
    a_intn_held: assert property (
        @(posedge clk) disable iff (rst24)
        (!mcu_intn && mcu_p2o[P2_IRQ_CLR_BIT]) |=> !mcu_intn
    ) else $error("mcu_intn released without clear");

endmodule

//--- hdl/cop_mcu_port_out.sv
/*
 * MCU output side. Assembles the 16-bit word the MCU writes toward the
 * CPU one byte at a time and decodes the ROM bank flags and the second
 * select from ports 1, 2 and 3
 */

`timescale 1ns/1ps

module cop_mcu_port_out import cop_pkg::*; (
    input  logic       clk,
    input  logic       rst24,
    input  byte_t      mcu_p0o,
    input  byte_t      mcu_p1o,
    input  byte_t      mcu_p2o,
    input  byte_t      mcu_p3o,
    output word_t      mcu_dout,
    output logic [2:1] sndflag,
    output logic [2:1] b1flg,
    output logic [2:1] mixflg,
    output logic       b0flg,
    output logic [2:0] crback,
    output logic       mcu_sel2
);

    logic wr_hi;
    logic wr_lo;

    assign wr_hi = ~mcu_p2o[P2_WRHI_BIT];
    assign wr_lo = ~mcu_p2o[P2_WRLO_BIT];

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            mcu_dout <= '0;
        end else begin
            // Each half is written on its own strobe
            if (wr_hi) begin
                mcu_dout[15:8] <= mcu_p0o;
            end
            if (wr_lo) begin
                mcu_dout[7:0] <= mcu_p0o;
            end
        end
    end

    // Bank flags packed from bit 6 down, bit 7 unused
    assign {sndflag, b1flg, b0flg, mixflg} = mcu_p1o[6:0];

    assign crback   = mcu_p3o[2:0];
    assign mcu_sel2 = mcu_p2o[P2_SEL2_BIT];

    // Word seen by the CPU holds while the MCU is not writing
    a_dout_stable: assert property (
        @(posedge clk) disable iff (rst24)
        (!wr_hi && !wr_lo) |=> $stable(mcu_dout)
    ) else $error("mcu_dout changed without a write strobe");

endmodule

//--- hdl/cop_status_mux.sv
/*
 * Status dump multiplexer. Registers one of four debug status bytes,
 * picked by the top two bits of the status address
 */

`timescale 1ns/1ps

module cop_status_mux import cop_pkg::*; (
    input  logic  clk,
    input  logic  rst24,
    input  byte_t st_addr,
    input  byte_t st_video,
    input  byte_t snd_latch,
    input  byte_t st_main,
    input  byte_t st_snd,
    output byte_t st_dout
);

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            st_dout <= '0;
        end else begin
            case (st_addr[ST_SEL_MSB -: 2])
                2'd0: st_dout <= st_video;
                2'd1: st_dout <= snd_latch;
                2'd2: st_dout <= st_main;
                default: st_dout <= st_snd;
            endcase
        end
    end

endmodule

//--- hdl/cop_board_glue.sv
/*
 * Board glue between the main CPU, the 8751 MCU ports and the status
 * port. Clock enables, MCU input and output sides and status readout
 */

`timescale 1ns/1ps

module cop_board_glue import cop_pkg::*; (
    input  logic       clk,
    input  logic       rst24,
    // CPU side
    input  word_t      mcu_din,
    input  sel_t       mcu_sel,
    output word_t      mcu_dout,
    output logic       mcu_sel2,
    // MCU ports
    input  byte_t      mcu_p0o,
    input  byte_t      mcu_p1o,
    input  byte_t      mcu_p2o,
    input  byte_t      mcu_p3o,
    output byte_t      mcu_p0i,
    output byte_t      mcu_p3i,
    output logic       mcu_intn,
    // ROM bank control
    output logic [2:1] sndflag,
    output logic [2:1] b1flg,
    output logic [2:1] mixflg,
    output logic       b0flg,
    output logic [2:0] crback,
    // Clock enables
    output logic       cen_mcu,
    output logic       cen_opl,
    output logic       cen_opn,
    // Status dump
    input  byte_t      st_addr,
    input  byte_t      st_video,
    input  byte_t      snd_latch,
    input  byte_t      st_main,
    input  byte_t      st_snd,
    output byte_t      st_dout
);

    cop_cen_gen u_cen (
        .clk      (clk),
        .rst24    (rst24),
        .cen_mcu  (cen_mcu),
        .cen_opl  (cen_opl),
        .cen_opn  (cen_opn)
    );

    cop_mcu_port_in u_port_in (
        .clk      (clk),
        .rst24    (rst24),
        .mcu_din  (mcu_din),
        .mcu_sel  (mcu_sel),
        .mcu_p2o  (mcu_p2o),
        .mcu_p3o  (mcu_p3o),
        .mcu_p0i  (mcu_p0i),
        .mcu_intn (mcu_intn),
        .mcu_p3i  (mcu_p3i)
    );

    cop_mcu_port_out u_port_out (
        .clk      (clk),
        .rst24    (rst24),
        .mcu_p0o  (mcu_p0o),
        .mcu_p1o  (mcu_p1o),
        .mcu_p2o  (mcu_p2o),
        .mcu_p3o  (mcu_p3o),
        .mcu_dout (mcu_dout),
        .sndflag  (sndflag),
        .b1flg    (b1flg),
        .mixflg   (mixflg),
        .b0flg    (b0flg),
        .crback   (crback),
        .mcu_sel2 (mcu_sel2)
    );

    cop_status_mux u_status (
        .clk       (clk),
        .rst24     (rst24),
        .st_addr   (st_addr),
        .st_video  (st_video),
        .snd_latch (snd_latch),
        .st_main   (st_main),
        .st_snd    (st_snd),
        .st_dout   (st_dout)
    );

endmodule

//--- verif/tb_checker.sv
/*
 * Testbench checker for the board glue. Models the clock enable, MCU
 * port and status rules, compares on every rising edge, counts errors
 */

`timescale 1ns/1ps

module tb_checker (
    input  logic        clk,
    input  logic        rst24,
    input  logic [15:0] mcu_din, mcu_dout,
    input  logic [5:0]  mcu_sel,
    input  logic [7:0]  mcu_p0o, mcu_p1o, mcu_p2o, mcu_p3o,
    input  logic [7:0]  mcu_p0i, mcu_p3i,
    input  logic        mcu_intn, mcu_sel2, b0flg,
    input  logic [2:1]  sndflag, b1flg, mixflg,
    input  logic [2:0]  crback,
    input  logic        cen_mcu, cen_opl, cen_opn,
    input  logic [7:0]  st_addr, st_video, snd_latch, st_main, st_snd, st_dout,
    input  logic        row_done,
    input  logic [7:0]  row_p0i,
    input  logic        row_intn,
    output int          errors
);

    logic [15:0] exp_dout;
    logic [7:0]  exp_p0i;
    logic [7:0]  exp_st;
    logic        exp_intn;
    logic        sel0_prev;
    bit          p0i_known;
    bit          rst_prev;
    int          gap_mcu, gap_opl, gap_opn;
    bit          seen_mcu, seen_opl, seen_opn;

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Gap counts cycles since the last pulse of one enable
    task automatic check_spacing(input string name, input logic pulse, input int div,
                                 inout int gap, inout bit seen);
        if (pulse) begin
            if (seen && gap != div) begin
                errors++;
                $display("%s pulse came %0d cycles after the previous one, not %0d",
                         name, gap, div);
            end
            gap = 1;
            seen = 1'b1;
        end else begin
            if (seen && gap >= div) begin
                errors++;
                $display("%s pulse missing %0d cycles after the previous one", name, gap);
            end
            gap = gap + 1;
        end
    endtask

    always @(posedge clk) begin
        if (rst24) begin
            // Skip the very first edge, registers may not be reset yet
            if (rst_prev) begin
                if (cen_mcu || cen_opl || cen_opn) begin
                    errors++;
                    $display("A clock enable was high during reset");
                end
                compare_value("mcu_dout", mcu_dout, 16'h0000);
                compare_value("st_dout", 16'(st_dout), 16'h0000);
                compare_value("mcu_intn", 16'(mcu_intn), 16'h0001);
            end
            exp_dout = '0;
            exp_st = '0;
            exp_intn = 1'b1;
            sel0_prev = 1'b0;
            p0i_known = 1'b0;
            seen_mcu = 1'b0;
            seen_opl = 1'b0;
            seen_opn = 1'b0;
        end else begin
            check_spacing("cen_mcu", cen_mcu, 3, gap_mcu, seen_mcu);
            check_spacing("cen_opl", cen_opl, 8, gap_opl, seen_opl);
            check_spacing("cen_opn", cen_opn, 16, gap_opn, seen_opn);
            if (cen_opn && !cen_opl) begin
                errors++;
                $display("cen_opn pulse did not coincide with a cen_opl pulse");
            end

            // Registered outputs against the model of the previous edge
            compare_value("mcu_dout", mcu_dout, exp_dout);
            compare_value("mcu_intn", 16'(mcu_intn), 16'(exp_intn));
            compare_value("st_dout", 16'(st_dout), 16'(exp_st));
            if (p0i_known) begin
                compare_value("mcu_p0i", 16'(mcu_p0i), 16'(exp_p0i));
            end

            // Bit fields of ports 1, 2 and 3
            compare_value("sndflag", 16'(sndflag), 16'(mcu_p1o[6:5]));
            compare_value("b1flg", 16'(b1flg), 16'(mcu_p1o[4:3]));
            compare_value("b0flg", 16'(b0flg), 16'(mcu_p1o[2]));
            compare_value("mixflg", 16'(mixflg), 16'(mcu_p1o[1:0]));
            compare_value("crback", 16'(crback), 16'(mcu_p3o[2:0]));
            compare_value("mcu_sel2", 16'(mcu_sel2), 16'(mcu_p2o[2]));
            compare_value("mcu_p3i", 16'(mcu_p3i), 16'({mcu_sel[5:3], mcu_p3o[4:0]}));

            // Expected levels from the stimulus table at the end of a row
            if (row_done) begin
                compare_value("mcu_p0i", 16'(mcu_p0i), 16'(row_p0i));
                compare_value("mcu_intn", 16'(mcu_intn), 16'(row_intn));
            end

            // Clear wins over a new select edge
            if (!mcu_p2o[3]) begin
                exp_intn = 1'b1;
            end else if (mcu_sel[0] && !sel0_prev) begin
                exp_intn = 1'b0;
            end
            sel0_prev = mcu_sel[0];

            if (!mcu_p2o[5]) begin
                exp_p0i = mcu_din[7:0];
                p0i_known = 1'b1;
            end else if (!mcu_p2o[4]) begin
                exp_p0i = mcu_din[15:8];
                p0i_known = 1'b1;
            end

            if (!mcu_p2o[7]) begin
                exp_dout[15:8] = mcu_p0o;
            end
            if (!mcu_p2o[6]) begin
                exp_dout[7:0] = mcu_p0o;
            end

            case (st_addr[7:6])
                2'd0: exp_st = st_video;
                2'd1: exp_st = snd_latch;
                2'd2: exp_st = st_main;
                default: exp_st = st_snd;
            endcase
        end
        rst_prev = rst24;
    end

endmodule

//--- verif/tb_top.sv
/*
 * Testbench top for the board glue. Clock, reset, a table of MCU port
 * rows applied in a loop, timeout and closing report
 */

`timescale 1ns/1ps

module tb_top;

    localparam int NROWS = 13;
    localparam int CYCLE_LIMIT = 16 + 4 * NROWS + 50;
    localparam int unsigned SEED = 32'hbab12671;

    typedef struct packed {
        logic [7:0]  p2;
        logic [7:0]  p1;
        logic [7:0]  p3;
        logic [7:0]  p0;
        logic [15:0] din;
        logic [7:0]  sel;
        logic [7:0]  st_addr;
        logic [7:0]  exp_p0i;
        logic [3:0]  exp_intn;
    } row_t;

    logic        clk;
    logic        rst24;
    logic [15:0] mcu_din, mcu_dout;
    logic [5:0]  mcu_sel;
    logic [7:0]  mcu_p0o, mcu_p1o, mcu_p2o, mcu_p3o;
    logic [7:0]  mcu_p0i, mcu_p3i;
    logic        mcu_intn, mcu_sel2, b0flg;
    logic [2:1]  sndflag, b1flg, mixflg;
    logic [2:0]  crback;
    logic        cen_mcu, cen_opl, cen_opn;
    logic [7:0]  st_addr, st_video, snd_latch, st_main, st_snd, st_dout;
    logic        row_done;
    logic [7:0]  row_p0i;
    logic        row_intn;
    int          errors;
    int          cycles;
    int unsigned seed_state;

    // Columns: p2 p1 p3 p0 din sel st_addr, then p0i and intn at row end
    row_t rows [NROWS] = '{
        76'hDF_00_00_00_1234_00_00_34_1,  // read low byte
        76'hEF_55_1F_11_A55A_00_40_A5_1,  // read high byte
        76'hDF_2A_E5_22_3C96_01_80_96_0,  // select rises, interrupt
        76'hCF_7F_0A_33_BEEF_00_C0_EF_0,  // both reads, low wins
        76'h7F_01_F8_C3_0000_38_3F_EF_0,  // write high byte
        76'hBF_40_07_5A_FFFF_01_7E_EF_0,  // write low byte, second edge
        76'hF7_08_10_66_0F0F_00_81_EF_1,  // clear
        76'hF7_04_02_77_F0F0_01_C2_EF_1,  // edge while clear held
        76'hFF_20_05_88_1111_01_13_EF_1,
        76'hFB_10_A0_99_2222_00_54_EF_1,  // second select low
        76'h3F_03_5C_AB_3333_2A_95_EF_1,  // both writes
        76'hFF_6D_33_CD_4444_07_D6_EF_0,
        76'hF7_00_00_00_5555_00_00_EF_1
    };

    cop_board_glue dut (.*);

    tb_checker chk (.*);

    always #4 clk = ~clk;

    task automatic apply_row(input row_t r);
        mcu_p2o = r.p2;
        mcu_p1o = r.p1;
        mcu_p3o = r.p3;
        mcu_p0o = r.p0;
        mcu_din = r.din;
        mcu_sel = r.sel[5:0];
        st_addr = r.st_addr;
        row_p0i = r.exp_p0i;
        row_intn = r.exp_intn[0];
        st_video = 8'($urandom);
        snd_latch = 8'($urandom);
        st_main = 8'($urandom);
        st_snd = 8'($urandom);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the row loop did not finish", cycles);
            $display("Checks done with %0d errors", errors);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        seed_state = $urandom(SEED);
        clk = 1'b0;
        rst24 = 1'b1;
        row_done = 1'b0;
        row_p0i = '0;
        row_intn = 1'b1;
        mcu_din = '0;
        mcu_sel = '0;
        mcu_p0o = '0;
        mcu_p1o = '0;
        mcu_p2o = 8'hFF;
        mcu_p3o = '0;
        st_addr = '0;
        st_video = '0;
        snd_latch = '0;
        st_main = '0;
        st_snd = '0;

        repeat (16) @(negedge clk);
        rst24 = 1'b0;

        // Each row holds for 4 cycles, the last edge checks the row
        for (int i = 0; i < NROWS; i++) begin
            @(negedge clk);
            apply_row(rows[i]);
            row_done = 1'b0;
            repeat (3) @(negedge clk);
            row_done = 1'b1;
        end
        @(negedge clk);
        row_done = 1'b0;
        repeat (2) @(negedge clk);

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sources.f
hdl/cop_pkg.sv
hdl/cop_cen_gen.sv
hdl/cop_mcu_port_in.sv
hdl/cop_mcu_port_out.sv
hdl/cop_status_mux.sv
hdl/cop_board_glue.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
# Compile the board glue testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_top -f sources.f

status=0
./obj_dir/Vtb_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log || [ "$status" -ne 0 ]; then
    echo "Run failed, see sim.log"
    exit 1
fi
echo "Run finished without errors"
